//--- common/dir_pkg.sv
package dir_pkg;

  // Physical address and cache line geometry for the scaled-down memory system
  localparam int paddr_bits = 16;
  localparam int line_bits  = 64;
  localparam int mask_bits  = 8;

  // Identifiers carried by L2 requests so the answer can be routed back
  localparam int nid_bits  = 5;
  localparam int l2id_bits = 6;

  // Command fields of requests and displacements
  localparam int cmd_bits  = 3;
  localparam int dcmd_bits = 2;
  // Response code width shared by memory acks and snoop-acks
  localparam int ack_bits  = 3;

  // A displacement with this command carries no data toward memory
  localparam logic [dcmd_bits-1:0] dcmd_invalidate = '0;

  // Directory request IDs track outstanding memory requests
  localparam int dr_reqids = 8;
  localparam int drid_bits = $clog2(dr_reqids);

  typedef struct packed {
    logic [paddr_bits-1:0] paddr;
    logic [cmd_bits-1:0]   cmd;
    logic [nid_bits-1:0]   nid;
    logic [l2id_bits-1:0]  l2id;
  } l2_req_t;

  typedef struct packed {
    logic [paddr_bits-1:0] paddr;
    logic [cmd_bits-1:0]   cmd;
    logic [drid_bits-1:0]  drid;
  } mem_req_t;

  typedef struct packed {
    logic [drid_bits-1:0] drid;
    logic [ack_bits-1:0]  ack;
    logic [line_bits-1:0] line;
  } mem_ack_t;

  typedef struct packed {
    logic [nid_bits-1:0]  nid;
    logic [l2id_bits-1:0] l2id;
    logic [ack_bits-1:0]  snack;
    logic [line_bits-1:0] line;
  } snack_t;

  typedef struct packed {
    logic [paddr_bits-1:0] paddr;
    logic [mask_bits-1:0]  mask;
    logic [line_bits-1:0]  line;
    logic [nid_bits-1:0]   nid;
    logic [l2id_bits-1:0]  l2id;
    logic [dcmd_bits-1:0]  dcmd;
  } disp_t;

  typedef struct packed {
    logic [paddr_bits-1:0] paddr;
    logic [mask_bits-1:0]  mask;
    logic [line_bits-1:0]  line;
  } wb_t;

  typedef struct packed {
    logic [nid_bits-1:0]  nid;
    logic [l2id_bits-1:0] l2id;
  } dack_t;

  typedef struct packed {
    logic [paddr_bits-1:0] paddr;
    logic [nid_bits-1:0]   nid;
  } pfreq_t;

  // Per-drid record of who asked, 11 bits wide
  typedef struct packed {
    logic [nid_bits-1:0]  nid;
    logic [l2id_bits-1:0] l2id;
  } id_entry_t;

endpackage

//--- logic/fluid_flop.sv
module fluid_flop #(
  parameter type payload_t = logic
) (
   input  logic     clk
  ,input  logic     rst_n

  ,input  payload_t din
  ,input  logic     din_valid
  ,output logic     din_retry

  ,output payload_t q
  ,output logic     q_valid
  ,input  logic     q_retry
);

  // Set when an item enters the register this cycle
  logic load;

  // The single entry is busy only while its output is being held back
  // An empty register or one that drains this cycle can always take a new item
  always_comb begin
    din_retry = q_valid && q_retry;
  end

  always_comb begin
    load = din_valid && !din_retry;
  end

  // Occupancy follows the input whenever the output is free to move
  // A held item keeps q_valid high until the consumer drops retry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_valid <= 1'b0;
    end else if (!din_retry) begin
      q_valid <= din_valid;
    end
  end

  // Payload only moves on an accepted transfer
  // While retried the output data stays frozen for the consumer
  always_ff @(posedge clk) begin
    if (load) begin
      q <= din;
    end
  end

endmodule

//--- directory/drid_allocator.sv
module drid_allocator import dir_pkg::*; (
   input  logic                 clk
  ,input  logic                 rst_n

  ,input  logic                 alloc_valid
  ,output logic                 alloc_retry

  ,output logic [drid_bits-1:0] drid
  ,output logic                 drid_valid
  ,input  logic                 drid_retry

  ,input  logic                 release_valid
  ,input  logic [drid_bits-1:0] release_drid
);

  // One bit per drid and a set bit means the ID may be handed out
  logic [dr_reqids-1:0] free_vec;
  logic [drid_bits-1:0] free_id;
  logic                 any_free;
  logic                 alloc_fire;

  // Priority encoder scanning from the top so the lowest free ID wins
  always_comb begin
    free_id  = '0;
    any_free = |free_vec;
    for (int i = dr_reqids - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        free_id = drid_bits'(i);
      end
    end
  end

  // No ID to give or the previous one still waits at the output
  always_comb begin
    alloc_retry = !any_free || (drid_valid && drid_retry);
  end

  always_comb begin
    alloc_fire = alloc_valid && !alloc_retry;
  end

  // Allocation and release never touch the same bit in one cycle
  // A released ID was in use so the encoder cannot be pointing at it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      free_vec <= '1;
    end else begin
      if (alloc_fire) begin
        free_vec[free_id] <= 1'b0;
      end
      if (release_valid) begin
        free_vec[release_drid] <= 1'b1;
      end
    end
  end

  // The issued ID sits here until the request join consumes it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drid_valid <= 1'b0;
    end else if (!(drid_valid && drid_retry)) begin
      drid_valid <= alloc_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      drid <= free_id;
    end
  end

endmodule

//--- directory/drid_table_arbiter.sv
module drid_table_arbiter import dir_pkg::*; (
   input  logic                 clk
  ,input  logic                 rst_n

  ,input  logic                 rd_valid
  ,input  logic [drid_bits-1:0] rd_drid
  ,output logic                 rd_retry

  ,input  logic                 wr_valid
  ,input  logic [drid_bits-1:0] wr_drid
  ,output logic                 wr_retry

  ,output logic                 tbl_valid
  ,output logic                 tbl_we
  ,output logic [drid_bits-1:0] tbl_pos
  ,input  logic                 tbl_retry
);

  // Two-state FSM holding which side wins a tie
  typedef enum logic {
    rd_pref = 1'b0,
    wr_pref = 1'b1
  } arb_state_t;

  arb_state_t state;
  arb_state_t state_next;
  logic       pick_rd;
  logic       rd_grant;
  logic       wr_grant;

  // Read goes to the table when it is preferred or when nothing is writing
  always_comb begin
    pick_rd   = rd_valid && (state == rd_pref || !wr_valid);
    tbl_valid = rd_valid || wr_valid;
    tbl_we    = !pick_rd && wr_valid;
    tbl_pos   = pick_rd ? rd_drid : wr_drid;
  end

  // Retries are built from the state and the other side only
  // This keeps each retry free of its own valid
  always_comb begin
    rd_retry = tbl_retry || (state == wr_pref && wr_valid);
    wr_retry = tbl_retry || (state == rd_pref && rd_valid);
  end

  always_comb begin
    rd_grant = rd_valid && !rd_retry;
    wr_grant = wr_valid && !wr_retry;
  end

  // After a granted access the other kind gets the next tie
  always_comb begin
    state_next = state;
    if (rd_grant) begin
      state_next = wr_pref;
    end else if (wr_grant) begin
      state_next = rd_pref;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= rd_pref;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- directory/drid_table.sv
module drid_table import dir_pkg::*; (
   input  logic                 clk
  ,input  logic                 rst_n

  ,input  logic                 req_valid
  ,output logic                 req_retry
  ,input  logic                 req_we
  ,input  logic [drid_bits-1:0] req_pos
  ,input  id_entry_t            req_data

  ,output logic                 ack_valid
  ,input  logic                 ack_retry
  ,output id_entry_t            ack_data
);

  // One nid and l2id pair per outstanding drid
  id_entry_t mem [dr_reqids];

  logic req_fire;
  logic rd_fire;
  logic wr_fire;

  // A read result that has not been taken blocks every new access
  always_comb begin
    req_retry = ack_valid && ack_retry;
  end

  always_comb begin
    req_fire = req_valid && !req_retry;
    rd_fire  = req_fire && !req_we;
    wr_fire  = req_fire && req_we;
  end

  // Writes land in the array at the clock edge and need no reply
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[req_pos] <= req_data;
    end
  end

  // Read data is registered so it shows up one cycle after the grant
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      ack_data <= mem[req_pos];
    end
  end

  // The read output stays valid while the consumer holds retry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_valid <= 1'b0;
    end else if (!req_retry) begin
      ack_valid <= rd_fire;
    end
  end

endmodule

//--- directory/disp_path.sv
module disp_path import dir_pkg::*; (
   input  logic  clk
  ,input  logic  rst_n

  ,input  logic  disp_valid
  ,output logic  disp_retry
  ,input  disp_t disp

  ,output logic  wb_valid
  ,input  logic  wb_retry
  ,output wb_t   wb

  ,output logic  dack_valid
  ,input  logic  dack_retry
  ,output dack_t dack
);

  wb_t   wb_next;
  dack_t dack_next;
  logic  need_wb;
  logic  wb_in_valid;
  logic  wb_in_retry;
  logic  dack_in_valid;
  logic  dack_in_retry;

  // Invalidate means the L2 dropped a clean line so memory gets nothing
  always_comb begin
    need_wb = disp.dcmd != dcmd_invalidate;
  end

  // Split the displacement into its memory part and its L2 part
  always_comb begin
    wb_next.paddr  = disp.paddr;
    wb_next.mask   = disp.mask;
    wb_next.line   = disp.line;
    dack_next.nid  = disp.nid;
    dack_next.l2id = disp.l2id;
  end

  // Each branch only fires when every needed branch can take it
  // The wb flop is ignored when no writeback is needed
  always_comb begin
    wb_in_valid   = disp_valid && need_wb && !dack_in_retry;
    dack_in_valid = disp_valid && !(need_wb && wb_in_retry);
    disp_retry    = dack_in_retry || (need_wb && wb_in_retry);
  end

  fluid_flop #(.payload_t(wb_t)) wb_ff (
     .clk       (clk)
    ,.rst_n     (rst_n)
    ,.din       (wb_next)
    ,.din_valid (wb_in_valid)
    ,.din_retry (wb_in_retry)
    ,.q         (wb)
    ,.q_valid   (wb_valid)
    ,.q_retry   (wb_retry)
  );

  fluid_flop #(.payload_t(dack_t)) dack_ff (
     .clk       (clk)
    ,.rst_n     (rst_n)
    ,.din       (dack_next)
    ,.din_valid (dack_in_valid)
    ,.din_retry (dack_in_retry)
    ,.q         (dack)
    ,.q_valid   (dack_valid)
    ,.q_retry   (dack_retry)
  );

endmodule

//--- directory/directory_bank.sv
module directory_bank import dir_pkg::*; (
   input  logic     clk
  ,input  logic     rst_n

  // L2 side
  ,input  logic     l2todr_req_valid
  ,output logic     l2todr_req_retry
  ,input  l2_req_t  l2todr_req

  ,input  logic     l2todr_pfreq_valid
  ,output logic     l2todr_pfreq_retry
  ,input  pfreq_t   l2todr_pfreq

  ,input  logic     l2todr_disp_valid
  ,output logic     l2todr_disp_retry
  ,input  disp_t    l2todr_disp

  ,output logic     drtol2_snack_valid
  ,input  logic     drtol2_snack_retry
  ,output snack_t   drtol2_snack

  ,output logic     drtol2_dack_valid
  ,input  logic     drtol2_dack_retry
  ,output dack_t    drtol2_dack

  // Memory side
  ,output logic     drtomem_req_valid
  ,input  logic     drtomem_req_retry
  ,output mem_req_t drtomem_req

  ,output logic     drtomem_pfreq_valid
  ,input  logic     drtomem_pfreq_retry
  ,output pfreq_t   drtomem_pfreq

  ,output logic     drtomem_wb_valid
  ,input  logic     drtomem_wb_retry
  ,output wb_t      drtomem_wb

  ,input  logic     memtodr_ack_valid
  ,output logic     memtodr_ack_retry
  ,input  mem_ack_t memtodr_ack
);

  // Request path between the L2 input and the memory request join
  l2_req_t              req_q;
  logic                 req_q_valid;
  logic                 req_in_valid;
  logic                 req_in_retry;
  logic                 alloc_valid;
  logic                 alloc_retry;
  logic [drid_bits-1:0] alloc_drid;
  logic                 alloc_drid_valid;
  logic                 join_valid;
  logic                 req_fire;

  // Table access from both sides of the arbiter
  logic                 tbl_wr_valid;
  logic                 tbl_wr_retry;
  logic                 tbl_rd_valid;
  logic                 tbl_rd_retry;
  logic                 tbl_valid;
  logic                 tbl_we;
  logic                 tbl_retry;
  logic [drid_bits-1:0] tbl_pos;
  id_entry_t            tbl_wr_data;
  id_entry_t            tbl_rd_data;
  logic                 tbl_rd_data_valid;

  // Memory ack path toward the snack join
  mem_ack_t             ack_q;
  logic                 ack_q_valid;
  logic                 ack_in_valid;
  logic                 ack_in_retry;
  logic                 snack_fire;

  // A request needs both a free flop slot and a fresh drid in the same cycle
  always_comb begin
    l2todr_req_retry = req_in_retry || alloc_retry;
    req_in_valid     = l2todr_req_valid && !alloc_retry;
    alloc_valid      = l2todr_req_valid && !req_in_retry;
  end

  fluid_flop #(.payload_t(l2_req_t)) req_ff (
     .clk(clk), .rst_n(rst_n)
    ,.din(l2todr_req), .din_valid(req_in_valid), .din_retry(req_in_retry)
    ,.q(req_q), .q_valid(req_q_valid), .q_retry(!req_fire)
  );

  drid_allocator allocator (
     .clk(clk), .rst_n(rst_n)
    ,.alloc_valid(alloc_valid), .alloc_retry(alloc_retry)
    ,.drid(alloc_drid), .drid_valid(alloc_drid_valid), .drid_retry(!req_fire)
    ,.release_valid(snack_fire), .release_drid(ack_q.drid)
  );

  // Request join feeding both memory and the table write
  // Memory only sees the request in a cycle where the table write is granted
  always_comb begin
    join_valid        = req_q_valid && alloc_drid_valid;
    drtomem_req_valid = join_valid && !tbl_wr_retry;
    tbl_wr_valid      = join_valid && !drtomem_req_retry;
    req_fire          = join_valid && !drtomem_req_retry && !tbl_wr_retry;
  end

  always_comb begin
    drtomem_req.paddr = req_q.paddr;
    drtomem_req.cmd   = req_q.cmd;
    drtomem_req.drid  = alloc_drid;
    tbl_wr_data.nid   = req_q.nid;
    tbl_wr_data.l2id  = req_q.l2id;
  end

  // The ack enters its flop and starts the table read together
  always_comb begin
    memtodr_ack_retry = ack_in_retry || tbl_rd_retry;
    ack_in_valid      = memtodr_ack_valid && !tbl_rd_retry;
    tbl_rd_valid      = memtodr_ack_valid && !ack_in_retry;
  end

  fluid_flop #(.payload_t(mem_ack_t)) ack_ff (
     .clk(clk), .rst_n(rst_n)
    ,.din(memtodr_ack), .din_valid(ack_in_valid), .din_retry(ack_in_retry)
    ,.q(ack_q), .q_valid(ack_q_valid), .q_retry(!snack_fire)
  );

  drid_table_arbiter arbiter (
     .clk(clk), .rst_n(rst_n)
    ,.rd_valid(tbl_rd_valid), .rd_drid(memtodr_ack.drid), .rd_retry(tbl_rd_retry)
    ,.wr_valid(tbl_wr_valid), .wr_drid(alloc_drid), .wr_retry(tbl_wr_retry)
    ,.tbl_valid(tbl_valid), .tbl_we(tbl_we), .tbl_pos(tbl_pos), .tbl_retry(tbl_retry)
  );

  drid_table table_i (
     .clk(clk), .rst_n(rst_n)
    ,.req_valid(tbl_valid), .req_retry(tbl_retry), .req_we(tbl_we)
    ,.req_pos(tbl_pos), .req_data(tbl_wr_data)
    ,.ack_valid(tbl_rd_data_valid), .ack_retry(!snack_fire), .ack_data(tbl_rd_data)
  );

  // Snack join of the held ack and the table lookup
  // Both halves were loaded together so they also leave together
  always_comb begin
    drtol2_snack_valid = ack_q_valid && tbl_rd_data_valid;
    snack_fire         = drtol2_snack_valid && !drtol2_snack_retry;
    drtol2_snack.nid   = tbl_rd_data.nid;
    drtol2_snack.l2id  = tbl_rd_data.l2id;
    drtol2_snack.snack = ack_q.ack;
    drtol2_snack.line  = ack_q.line;
  end

  disp_path disp_i (
     .clk(clk), .rst_n(rst_n)
    ,.disp_valid(l2todr_disp_valid), .disp_retry(l2todr_disp_retry), .disp(l2todr_disp)
    ,.wb_valid(drtomem_wb_valid), .wb_retry(drtomem_wb_retry), .wb(drtomem_wb)
    ,.dack_valid(drtol2_dack_valid), .dack_retry(drtol2_dack_retry), .dack(drtol2_dack)
  );

  // Prefetches carry no ID and go straight to memory
  fluid_flop #(.payload_t(pfreq_t)) pfreq_ff (
     .clk(clk), .rst_n(rst_n)
    ,.din(l2todr_pfreq), .din_valid(l2todr_pfreq_valid), .din_retry(l2todr_pfreq_retry)
    ,.q(drtomem_pfreq), .q_valid(drtomem_pfreq_valid), .q_retry(drtomem_pfreq_retry)
  );

endmodule

//--- tb/tb_directory_bank.sv
module tb_directory_bank import dir_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period   = 4;
  localparam int reset_cycles = 10;
  localparam int n_req        = 12;
  localparam int n_disp       = 8;
  localparam int n_pf         = 12;

  logic     clk;
  logic     rst_n;
  logic     l2todr_req_valid;
  logic     l2todr_req_retry;
  l2_req_t  l2todr_req;
  logic     l2todr_pfreq_valid;
  logic     l2todr_pfreq_retry;
  pfreq_t   l2todr_pfreq;
  logic     l2todr_disp_valid;
  logic     l2todr_disp_retry;
  disp_t    l2todr_disp;
  logic     drtol2_snack_valid;
  logic     drtol2_snack_retry;
  snack_t   drtol2_snack;
  logic     drtol2_dack_valid;
  logic     drtol2_dack_retry;
  dack_t    drtol2_dack;
  logic     drtomem_req_valid;
  logic     drtomem_req_retry;
  mem_req_t drtomem_req;
  logic     drtomem_pfreq_valid;
  logic     drtomem_pfreq_retry;
  pfreq_t   drtomem_pfreq;
  logic     drtomem_wb_valid;
  logic     drtomem_wb_retry;
  wb_t      drtomem_wb;
  logic     memtodr_ack_valid;
  logic     memtodr_ack_retry;
  mem_ack_t memtodr_ack;

  // Request stimulus in the order the L2 issues it (paddr, cmd, nid, l2id)
  l2_req_t req_table [n_req] = '{
    '{16'h0100, 3'd1, 5'd1,  6'd3},
    '{16'h0140, 3'd2, 5'd2,  6'd7},
    '{16'h0180, 3'd3, 5'd3,  6'd11},
    '{16'h1a00, 3'd1, 5'd4,  6'd12},
    '{16'h1a40, 3'd4, 5'd5,  6'd20},
    '{16'h2b80, 3'd5, 5'd6,  6'd21},
    '{16'h3cc0, 3'd6, 5'd7,  6'd33},
    '{16'h4d00, 3'd7, 5'd8,  6'd40},
    '{16'h5e40, 3'd2, 5'd9,  6'd41},
    '{16'h6f80, 3'd3, 5'd30, 6'd50},
    '{16'h7fc0, 3'd0, 5'd31, 6'd62},
    '{16'hfff0, 3'd1, 5'd0,  6'd63}
  };

  // Displacement stimulus (paddr, mask, line, nid, l2id, dcmd)
  // The line field is refilled with random data when the entry is sent
  disp_t disp_table [n_disp] = '{
    '{16'h2000, 8'hff, 64'h0, 5'd2,  6'd1,  2'd1},
    '{16'h2040, 8'h0f, 64'h0, 5'd3,  6'd2,  2'd0},
    '{16'h2080, 8'hf0, 64'h0, 5'd4,  6'd5,  2'd2},
    '{16'h20c0, 8'h81, 64'h0, 5'd5,  6'd9,  2'd3},
    '{16'h3000, 8'h00, 64'h0, 5'd6,  6'd17, 2'd0},
    '{16'h3040, 8'h3c, 64'h0, 5'd7,  6'd33, 2'd1},
    '{16'h3080, 8'hff, 64'h0, 5'd29, 6'd60, 2'd0},
    '{16'h30c0, 8'h55, 64'h0, 5'd31, 6'd63, 2'd2}
  };

  // Reference model of the drid pool and the per-drid table
  logic [dr_reqids-1:0] model_free;
  id_entry_t            id_model [dr_reqids];
  mem_req_t             exp_mem [$];
  logic [drid_bits-1:0] pending [$];
  mem_ack_t             acks_sent [$];
  wb_t                  exp_wb [$];
  dack_t                exp_dack [$];
  pfreq_t               exp_pf [$];

  int mem_req_count;
  int snack_count;
  int wb_count;
  int dack_count;
  int pf_count;
  int n_wb;

  logic                 ack_enable;
  logic                 ack_taken;
  logic                 bp_on;
  logic                 released_any;
  logic [drid_bits-1:0] last_mem_drid;
  logic [drid_bits-1:0] first_release_drid;
  logic                 snack_held;
  snack_t               held_snack;
  logic                 pf_held;
  pfreq_t               held_pf;

  directory_bank uut (
     .clk(clk), .rst_n(rst_n)
    ,.l2todr_req_valid(l2todr_req_valid), .l2todr_req_retry(l2todr_req_retry)
    ,.l2todr_req(l2todr_req)
    ,.l2todr_pfreq_valid(l2todr_pfreq_valid), .l2todr_pfreq_retry(l2todr_pfreq_retry)
    ,.l2todr_pfreq(l2todr_pfreq)
    ,.l2todr_disp_valid(l2todr_disp_valid), .l2todr_disp_retry(l2todr_disp_retry)
    ,.l2todr_disp(l2todr_disp)
    ,.drtol2_snack_valid(drtol2_snack_valid), .drtol2_snack_retry(drtol2_snack_retry)
    ,.drtol2_snack(drtol2_snack)
    ,.drtol2_dack_valid(drtol2_dack_valid), .drtol2_dack_retry(drtol2_dack_retry)
    ,.drtol2_dack(drtol2_dack)
    ,.drtomem_req_valid(drtomem_req_valid), .drtomem_req_retry(drtomem_req_retry)
    ,.drtomem_req(drtomem_req)
    ,.drtomem_pfreq_valid(drtomem_pfreq_valid), .drtomem_pfreq_retry(drtomem_pfreq_retry)
    ,.drtomem_pfreq(drtomem_pfreq)
    ,.drtomem_wb_valid(drtomem_wb_valid), .drtomem_wb_retry(drtomem_wb_retry)
    ,.drtomem_wb(drtomem_wb)
    ,.memtodr_ack_valid(memtodr_ack_valid), .memtodr_ack_retry(memtodr_ack_retry)
    ,.memtodr_ack(memtodr_ack)
  );

  initial begin
    clk = 1'b0;
  end

  always #(clk_period / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("error at %0t ns: %s is %0h, expected %0h",
                          $time, name, actual, expected));
    end
  endtask

  // Lowest set bit of the model's free vector
  function automatic logic [drid_bits-1:0] lowest_free(input logic [dr_reqids-1:0] v);
    for (int i = 0; i < dr_reqids; i++) begin
      if (v[i]) begin
        return drid_bits'(i);
      end
    end
    return '0;
  endfunction

  task automatic send_req(input l2_req_t r);
    @(negedge clk);
    l2todr_req       = r;
    l2todr_req_valid = 1'b1;
    @(posedge clk);
    while (l2todr_req_retry) @(posedge clk);
  endtask

  task automatic send_disp(input disp_t d);
    @(negedge clk);
    l2todr_disp       = d;
    l2todr_disp_valid = 1'b1;
    @(posedge clk);
    while (l2todr_disp_retry) @(posedge clk);
  endtask

  task automatic send_pf(input pfreq_t p);
    @(negedge clk);
    l2todr_pfreq       = p;
    l2todr_pfreq_valid = 1'b1;
    @(posedge clk);
    while (l2todr_pfreq_retry) @(posedge clk);
  endtask

  // Random retries on the DUT outputs, changed only on the falling edge
  always @(negedge clk) begin : backpressure
    drtol2_snack_retry  = bp_on && ($urandom % 3 == 0);
    drtol2_dack_retry   = bp_on && ($urandom % 4 == 0);
    drtomem_req_retry   = bp_on && ($urandom % 4 == 0);
    drtomem_wb_retry    = bp_on && ($urandom % 3 == 0);
    drtomem_pfreq_retry = bp_on && ($urandom % 2 == 0);
  end

  // Memory answers outstanding requests in a scrambled order
  always @(negedge clk) begin : mem_responder
    int       pick;
    mem_ack_t nxt;
    if (ack_taken) begin
      memtodr_ack_valid = 1'b0;
      ack_taken         = 1'b0;
    end
    if (!memtodr_ack_valid && ack_enable && pending.size() > 0) begin
      pick      = int'($urandom % pending.size());
      nxt.drid  = pending[pick];
      nxt.ack   = 3'($urandom);
      nxt.line  = {$urandom, $urandom};
      pending.delete(pick);
      memtodr_ack       = nxt;
      memtodr_ack_valid = 1'b1;
    end
  end

  // All transfers are judged on the rising edge against the model
  always @(posedge clk) begin : monitor
    logic [drid_bits-1:0] d;
    mem_req_t             m;
    mem_ack_t             a;
    wb_t                  w;
    dack_t                k;
    pfreq_t               p;
    if (rst_n) begin
      // The drid is the lowest one free when the request is accepted
      if (l2todr_req_valid && !l2todr_req_retry) begin
        if (model_free == '0) begin
          abort_run("a request was accepted while every drid was in use");
        end else begin
          d = lowest_free(model_free);
          model_free[d]   = 1'b0;
          id_model[d]     = '{nid: l2todr_req.nid, l2id: l2todr_req.l2id};
          m.paddr = l2todr_req.paddr;
          m.cmd   = l2todr_req.cmd;
          m.drid  = d;
          exp_mem.push_back(m);
        end
      end
      if (drtomem_req_valid && !drtomem_req_retry) begin
        if (exp_mem.size() == 0) begin
          abort_run("a memory request appeared with no accepted L2 request behind it");
        end else begin
          m = exp_mem.pop_front();
          check("drtomem_req", drtomem_req, m);
          // Right after reset the drids come out in order
          if (mem_req_count < dr_reqids) begin
            check("drtomem_req.drid", drtomem_req.drid, mem_req_count);
          end
          pending.push_back(drtomem_req.drid);
          last_mem_drid = drtomem_req.drid;
          mem_req_count++;
        end
      end
      if (memtodr_ack_valid && !memtodr_ack_retry) begin
        acks_sent.push_back(memtodr_ack);
        ack_taken = 1'b1;
      end
      // Snacks leave in ack order and free their drid for the next cycle
      if (drtol2_snack_valid && !drtol2_snack_retry) begin
        if (acks_sent.size() == 0) begin
          abort_run("a snack appeared with no memory ack behind it");
        end else begin
          a = acks_sent.pop_front();
          check("drtol2_snack.nid", drtol2_snack.nid, id_model[a.drid].nid);
          check("drtol2_snack.l2id", drtol2_snack.l2id, id_model[a.drid].l2id);
          check("drtol2_snack.snack", drtol2_snack.snack, a.ack);
          check("drtol2_snack.line", drtol2_snack.line, a.line);
          model_free[a.drid] = 1'b1;
          if (!released_any) begin
            first_release_drid = a.drid;
          end
          released_any = 1'b1;
          snack_count++;
        end
      end
      if (snack_held) begin
        check("drtol2_snack_valid", drtol2_snack_valid, 1'b1);
        check("drtol2_snack.id", {drtol2_snack.nid, drtol2_snack.l2id, drtol2_snack.snack},
              {held_snack.nid, held_snack.l2id, held_snack.snack});
        check("drtol2_snack.line", drtol2_snack.line, held_snack.line);
      end
      snack_held = drtol2_snack_valid && drtol2_snack_retry;
      held_snack = drtol2_snack;
      // Invalidates expect only the dack
      if (l2todr_disp_valid && !l2todr_disp_retry) begin
        k.nid  = l2todr_disp.nid;
        k.l2id = l2todr_disp.l2id;
        exp_dack.push_back(k);
        if (l2todr_disp.dcmd != dcmd_invalidate) begin
          w.paddr = l2todr_disp.paddr;
          w.mask  = l2todr_disp.mask;
          w.line  = l2todr_disp.line;
          exp_wb.push_back(w);
        end
      end
      if (drtomem_wb_valid && !drtomem_wb_retry) begin
        if (exp_wb.size() == 0) begin
          abort_run("a writeback appeared that no displacement asked for");
        end else begin
          w = exp_wb.pop_front();
          check("drtomem_wb.paddr", drtomem_wb.paddr, w.paddr);
          check("drtomem_wb.mask", drtomem_wb.mask, w.mask);
          check("drtomem_wb.line", drtomem_wb.line, w.line);
          wb_count++;
        end
      end
      if (drtol2_dack_valid && !drtol2_dack_retry) begin
        if (exp_dack.size() == 0) begin
          abort_run("a dack appeared that no displacement asked for");
        end else begin
          k = exp_dack.pop_front();
          check("drtol2_dack", drtol2_dack, k);
          dack_count++;
        end
      end
      if (l2todr_pfreq_valid && !l2todr_pfreq_retry) begin
        exp_pf.push_back(l2todr_pfreq);
      end
      if (drtomem_pfreq_valid && !drtomem_pfreq_retry) begin
        if (exp_pf.size() == 0) begin
          abort_run("a prefetch reached memory more often than it was sent");
        end else begin
          p = exp_pf.pop_front();
          check("drtomem_pfreq", drtomem_pfreq, p);
          pf_count++;
        end
      end
      if (pf_held) begin
        check("drtomem_pfreq_valid", drtomem_pfreq_valid, 1'b1);
        check("drtomem_pfreq", drtomem_pfreq, held_pf);
      end
      pf_held = drtomem_pfreq_valid && drtomem_pfreq_retry;
      held_pf = drtomem_pfreq;
    end
  end

  // Limit scales with the number of table entries
  initial begin : watchdog
    #(clk_period * (reset_cycles + 200 * (n_req + n_disp + n_pf)));
    abort_run("timeout: the DUT stopped making progress before all traffic finished");
  end

  initial begin : main
    disp_t       dd;
    pfreq_t      pp;
    void'($urandom(32'h990));
    rst_n               = 1'b0;
    l2todr_req_valid    = 1'b0;
    l2todr_req          = '0;
    l2todr_pfreq_valid  = 1'b0;
    l2todr_pfreq        = '0;
    l2todr_disp_valid   = 1'b0;
    l2todr_disp         = '0;
    drtol2_snack_retry  = 1'b0;
    drtol2_dack_retry   = 1'b0;
    drtomem_req_retry   = 1'b0;
    drtomem_pfreq_retry = 1'b0;
    drtomem_wb_retry    = 1'b0;
    memtodr_ack_valid   = 1'b0;
    memtodr_ack         = '0;
    model_free    = '1;
    ack_enable    = 1'b0;
    ack_taken     = 1'b0;
    bp_on         = 1'b0;
    released_any  = 1'b0;
    snack_held    = 1'b0;
    pf_held       = 1'b0;
    mem_req_count = 0;
    snack_count   = 0;
    wb_count      = 0;
    dack_count    = 0;
    pf_count      = 0;
    n_wb          = 0;

    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle outputs and open input channels once reset is gone
    @(posedge clk);
    check("drtol2_snack_valid", drtol2_snack_valid, 1'b0);
    check("drtol2_dack_valid", drtol2_dack_valid, 1'b0);
    check("drtomem_req_valid", drtomem_req_valid, 1'b0);
    check("drtomem_pfreq_valid", drtomem_pfreq_valid, 1'b0);
    check("drtomem_wb_valid", drtomem_wb_valid, 1'b0);
    check("l2todr_req_retry", l2todr_req_retry, 1'b0);
    check("l2todr_pfreq_retry", l2todr_pfreq_retry, 1'b0);
    check("l2todr_disp_retry", l2todr_disp_retry, 1'b0);
    check("memtodr_ack_retry", memtodr_ack_retry, 1'b0);
    bp_on = 1'b1;

    // Fill the whole drid pool while memory stays silent
    for (int i = 0; i < dr_reqids; i++) begin
      send_req(req_table[i]);
    end
    @(negedge clk);
    l2todr_req_valid = 1'b0;
    while (mem_req_count < dr_reqids) @(negedge clk);

    // A ninth request has to wait for a drid to come back
    l2todr_req       = req_table[dr_reqids];
    l2todr_req_valid = 1'b1;
    repeat (8) begin
      @(posedge clk);
      check("l2todr_req_retry", l2todr_req_retry, 1'b1);
    end
    @(negedge clk);
    check("memory requests while exhausted", mem_req_count, dr_reqids);
    ack_enable = 1'b1;
    @(posedge clk);
    while (l2todr_req_retry) @(posedge clk);
    @(negedge clk);
    l2todr_req_valid = 1'b0;
    // The ninth memory request reuses the drid freed by the first snack
    while (mem_req_count <= dr_reqids) @(negedge clk);
    check("ninth request drid", last_mem_drid, first_release_drid);

    for (int i = dr_reqids + 1; i < n_req; i++) begin
      send_req(req_table[i]);
    end
    @(negedge clk);
    l2todr_req_valid = 1'b0;
    while (snack_count < n_req) @(negedge clk);

    // Displacements with and without data
    for (int i = 0; i < n_disp; i++) begin
      dd      = disp_table[i];
      dd.line = {$urandom, $urandom};
      if (dd.dcmd != dcmd_invalidate) begin
        n_wb++;
      end
      send_disp(dd);
    end
    @(negedge clk);
    l2todr_disp_valid = 1'b0;
    while (dack_count < n_disp || exp_wb.size() > 0) @(negedge clk);

    // Prefetches under heavy back-pressure
    for (int i = 0; i < n_pf; i++) begin
      pp.paddr = 16'($urandom);
      pp.nid   = 5'($urandom);
      send_pf(pp);
    end
    @(negedge clk);
    l2todr_pfreq_valid = 1'b0;
    while (pf_count < n_pf) @(negedge clk);

    // Nothing late or extra may show up once traffic stops
    repeat (20) @(negedge clk);
    check("memory request count", mem_req_count, n_req);
    check("snack count", snack_count, n_req);
    check("unanswered requests", pending.size(), 0);
    check("writeback count", wb_count, n_wb);
    check("dack count", dack_count, n_disp);
    check("prefetch count", pf_count, n_pf);
    $display("All tests passed");
    $finish;
  end

endmodule

//--- flist.f
common/dir_pkg.sv
logic/fluid_flop.sv
directory/drid_allocator.sv
directory/drid_table_arbiter.sv
directory/drid_table.sv
directory/disp_path.sv
directory/directory_bank.sv
tb/tb_directory_bank.sv

//--- Makefile
# Verilator build and run for the directory bank testbench
VERILATOR ?= verilator
TOP       ?= tb_directory_bank
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= All tests passed

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
